/* source/wbx_pkg.sv */
////////////////////////////////////////
// Shared definitions for the integer
// back-end pipeline: opcodes, fault
// status codes and instruction layout
////////////////////////////////////////

package wbx_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int XLEN  = 32;
  // Number of architectural registers
  localparam int NREGS = 16;

  // Register address
  typedef logic [3:0] reg_addr_t;

  ////////////////////////////////////////
  // Instruction field layout
  ////////////////////////////////////////

  // Opcode
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  // Destination register
  localparam int RD_MSB  = 27;
  localparam int RD_LSB  = 24;
  // First source register
  localparam int RS1_MSB = 23;
  localparam int RS1_LSB = 20;
  // Second source register
  localparam int RS2_MSB = 19;
  localparam int RS2_LSB = 16;
  // Immediate, sign-extended to XLEN
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;
  localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Opcodes, all other codes are illegal
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADDI = 4'h4,
    OP_LOAD = 4'h5
  } op_e;

  // Retirement status
  typedef enum logic [2:0] {
    ST_OK       = 3'd0,
    ST_ILLEGAL  = 3'd1,
    ST_MISALIGN = 3'd2,
    ST_PROTECT  = 3'd3,
    ST_WATCH    = 3'd4
  } status_e;

endpackage

/* source/reg_file.sv */
////////////////////////////////////////
// Register file: 16 x 32, two read
// ports, one write port, write-through
////////////////////////////////////////

`timescale 1ns/100ps

module reg_file import wbx_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // Read ports
  input  reg_addr_t       raddr_a_i,
  input  reg_addr_t       raddr_b_i,
  output logic [XLEN-1:0] rdata_a_o,
  output logic [XLEN-1:0] rdata_b_o,
  // Write port
  input  logic            we_i,
  input  reg_addr_t       waddr_i,
  input  logic [XLEN-1:0] wdata_i
);

  logic [XLEN-1:0] regs_q [NREGS];
  logic            wr_en;

  // r0 stays zero
  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Same-cycle write is visible to decode
  assign rdata_a_o = (wr_en && (waddr_i == raddr_a_i)) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (wr_en && (waddr_i == raddr_b_i)) ? wdata_i : regs_q[raddr_b_i];

endmodule

/* source/instr_decoder.sv */
////////////////////////////////////////
// Decode stage: splits the instruction
// word, reads operands and registers
// the ID/EX fields
////////////////////////////////////////

`timescale 1ns/100ps

module instr_decoder import wbx_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // Host strobe
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic            stall_i,
  // Register file read ports
  output reg_addr_t       rs1_addr_o,
  output reg_addr_t       rs2_addr_o,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  // ID/EX
  output logic            id_valid_o,
  output op_e             id_op_o,
  output reg_addr_t       id_rd_o,
  output reg_addr_t       id_rs1_o,
  output reg_addr_t       id_rs2_o,
  output logic [XLEN-1:0] id_a_o,
  output logic [XLEN-1:0] id_b_o,
  output logic [XLEN-1:0] id_imm_o,
  output logic            id_illegal_o
);

  op_e             op;
  logic            illegal;
  logic [XLEN-1:0] imm_ext;

  // Field split
  assign op         = op_e'(instr_i[OPC_MSB:OPC_LSB]);
  assign rs1_addr_o = instr_i[RS1_MSB:RS1_LSB];
  assign rs2_addr_o = instr_i[RS2_MSB:RS2_LSB];
  // Sign extension of the immediate
  assign imm_ext    = {{(XLEN-IMM_W){instr_i[IMM_MSB]}}, instr_i[IMM_MSB:IMM_LSB]};

  // Anything outside the opcode table is illegal
  always_comb begin
    unique case (op)
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LOAD: illegal = 1'b0;
      default:                                          illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  // Control part, a bubble enters when nothing is strobed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o   <= 1'b0;
      id_illegal_o <= 1'b0;
    end else if (!stall_i) begin
      id_valid_o   <= instr_valid_i;
      id_illegal_o <= instr_valid_i && illegal;
    end
  end

  // Payload only moves with a real instruction
  always_ff @(posedge clk) begin
    if (!stall_i && instr_valid_i) begin
      id_op_o  <= op;
      id_rd_o  <= instr_i[RD_MSB:RD_LSB];
      id_rs1_o <= rs1_addr_o;
      id_rs2_o <= rs2_addr_o;
      // Operands may be stale here, execute forwards over them
      id_a_o   <= rs1_data_i;
      id_b_o   <= rs2_data_i;
      id_imm_o <= imm_ext;
    end
  end

endmodule

/* source/alu_execute.sv */
////////////////////////////////////////
// Execute stage: forwarding from write
// back, ALU and load address, EX/WB
////////////////////////////////////////

`timescale 1ns/100ps

module alu_execute import wbx_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall_i,
  // ID/EX
  input  logic            id_valid_i,
  input  op_e             id_op_i,
  input  reg_addr_t       id_rd_i,
  input  reg_addr_t       id_rs1_i,
  input  reg_addr_t       id_rs2_i,
  input  logic [XLEN-1:0] id_a_i,
  input  logic [XLEN-1:0] id_b_i,
  input  logic [XLEN-1:0] id_imm_i,
  input  logic            id_illegal_i,
  // Forwarding source from write back
  input  logic            fwd_we_i,
  input  reg_addr_t       fwd_addr_i,
  input  logic [XLEN-1:0] fwd_data_i,
  // EX/WB
  output logic            ex_valid_o,
  output reg_addr_t       ex_rd_o,
  output logic            ex_we_o,
  output logic            ex_lsu_en_o,
  output logic [XLEN-1:0] ex_result_o,
  output status_e         ex_status_o
);

  logic            fwd_a;
  logic            fwd_b;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] result;

  // r0 is never forwarded
  assign fwd_a = fwd_we_i && (fwd_addr_i == id_rs1_i) && (id_rs1_i != '0);
  assign fwd_b = fwd_we_i && (fwd_addr_i == id_rs2_i) && (id_rs2_i != '0);
  assign opa   = fwd_a ? fwd_data_i : id_a_i;
  assign opb   = fwd_b ? fwd_data_i : id_b_i;

  // ALU, loads reuse the immediate adder for the address
  always_comb begin
    unique case (id_op_i)
      OP_ADD:           result = opa + opb;
      OP_SUB:           result = opa - opb;
      OP_AND:           result = opa & opb;
      OP_XOR:           result = opa ^ opb;
      OP_ADDI, OP_LOAD: result = opa + id_imm_i;
      default:          result = '0;
    endcase
  end

  // EX/WB control, illegal instructions carry a status and no write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o  <= 1'b0;
      ex_we_o     <= 1'b0;
      ex_lsu_en_o <= 1'b0;
      ex_status_o <= ST_OK;
    end else if (!stall_i) begin
      ex_valid_o  <= id_valid_i;
      ex_we_o     <= id_valid_i && !id_illegal_i;
      ex_lsu_en_o <= id_valid_i && !id_illegal_i && (id_op_i == OP_LOAD);
      ex_status_o <= (id_valid_i && id_illegal_i) ? ST_ILLEGAL : ST_OK;
    end
  end

  // EX/WB payload
  always_ff @(posedge clk) begin
    if (!stall_i && id_valid_i) begin
      ex_rd_o     <= id_rd_i;
      ex_result_o <= result;
    end
  end

endmodule

/* source/load_unit.sv */
////////////////////////////////////////
// Load unit: fault checks, one bus
// request per clean load, and a single
// result pulse to write back
////////////////////////////////////////

`timescale 1ns/100ps

module load_unit import wbx_pkg::*; #(
  // Size of the permitted data range in bytes
  parameter int DATA_LIMIT = 4096
) (
  input  logic            clk,
  input  logic            rst_n,
  // Load entry from write back
  input  logic            start_i,
  input  logic [XLEN-1:0] addr_i,
  // Debug watch address
  input  logic            watch_en_i,
  input  logic [XLEN-1:0] watch_addr_i,
  // Data bus
  output logic            data_req_o,
  output logic [XLEN-1:0] data_addr_o,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,
  // Result to write back
  output logic            lsu_valid_o,
  output logic [XLEN-1:0] lsu_rdata_o,
  output status_e         lsu_status_o
);

  localparam logic [XLEN-1:0] LIMIT_ADDR = XLEN'(DATA_LIMIT);

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_WAIT,
    LSU_REPORT
  } lsu_state_e;

  lsu_state_e      state_q;
  lsu_state_e      state_d;
  status_e         fault_status;
  status_e         status_q;
  logic [XLEN-1:0] rdata_q;
  logic            issue;

  // Fault priority: alignment, range, then watch match
  always_comb begin
    if (addr_i[1:0] != 2'b00) begin
      fault_status = ST_MISALIGN;
    end else if (addr_i >= LIMIT_ADDR) begin
      fault_status = ST_PROTECT;
    end else if (watch_en_i && (addr_i == watch_addr_i)) begin
      fault_status = ST_WATCH;
    end else begin
      fault_status = ST_OK;
    end
  end

  // Single-cycle request on entry of a clean load
  assign issue       = (state_q == LSU_IDLE) && start_i && (fault_status == ST_OK);
  assign data_req_o  = issue;
  assign data_addr_o = addr_i;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      LSU_IDLE: begin
        // Faults and zero-latency responses report right away
        if (start_i) begin
          state_d = ((fault_status != ST_OK) || data_rvalid_i) ? LSU_REPORT : LSU_WAIT;
        end
      end
      LSU_WAIT:   if (data_rvalid_i) state_d = LSU_REPORT;
      LSU_REPORT: state_d = LSU_IDLE;
      default:    state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= LSU_IDLE;
      status_q <= ST_OK;
    end else begin
      state_q <= state_d;
      if ((state_q == LSU_IDLE) && start_i) begin
        status_q <= fault_status;
      end
    end
  end

  // Response data
  always_ff @(posedge clk) begin
    if ((issue || (state_q == LSU_WAIT)) && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign lsu_valid_o  = (state_q == LSU_REPORT);
  assign lsu_rdata_o  = rdata_q;
  assign lsu_status_o = status_q;

endmodule

/* source/wb_stage.sv */
////////////////////////////////////////
// Write-back stage: sticky load result,
// gated register write, retirement
////////////////////////////////////////

`timescale 1ns/100ps

module wb_stage import wbx_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // EX/WB
  input  logic            ex_valid_i,
  input  reg_addr_t       ex_rd_i,
  input  logic            ex_we_i,
  input  logic            ex_lsu_en_i,
  input  logic [XLEN-1:0] ex_result_i,
  input  status_e         ex_status_i,
  // Debug halt
  input  logic            halt_i,
  // Load unit
  input  logic            lsu_valid_i,
  input  logic [XLEN-1:0] lsu_rdata_i,
  input  status_e         lsu_status_i,
  output logic            lsu_start_o,
  // Pipeline hold
  output logic            wb_stall_o,
  // Register file write
  output logic            rf_we_o,
  output reg_addr_t       rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,
  // Retirement
  output logic            retire_valid_o,
  output status_e         retire_status_o
);

  logic            instr_valid;
  logic            wb_valid;
  logic            lsu_valid;
  logic [XLEN-1:0] lsu_rdata;
  status_e         lsu_status;
  status_e         wb_status;

  // Sticky copies of the load result
  logic            lsu_valid_q;
  logic [XLEN-1:0] lsu_rdata_q;
  status_e         lsu_status_q;
  // Load already handed to the load unit
  logic            lsu_started_q;

  // Halt blocks retirement but not the load itself
  assign instr_valid = ex_valid_i && !halt_i;

  // Live pulse or held copy
  assign lsu_valid  = lsu_valid_q || lsu_valid_i;
  assign lsu_rdata  = lsu_valid_q ? lsu_rdata_q  : lsu_rdata_i;
  assign lsu_status = lsu_valid_q ? lsu_status_q : lsu_status_i;

  // Non-loads are done at once, loads once their result is in
  assign wb_valid   = (!ex_lsu_en_i || lsu_valid) && instr_valid;
  assign wb_status  = ex_lsu_en_i ? lsu_status : ex_status_i;
  assign wb_stall_o = ex_valid_i && !wb_valid;

  // First cycle of a load in this stage
  assign lsu_start_o = ex_valid_i && ex_lsu_en_i && !lsu_started_q;

  ////////////////////////////////////////
  // Register write and retirement
  ////////////////////////////////////////

  // Any fault suppresses the write
  assign rf_we_o    = wb_valid && ex_we_i && (wb_status == ST_OK);
  assign rf_waddr_o = ex_rd_i;
  assign rf_wdata_o = ex_lsu_en_i ? lsu_rdata : ex_result_i;

  assign retire_valid_o  = wb_valid;
  assign retire_status_o = wb_status;

  ////////////////////////////////////////
  // Sticky state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_valid_q   <= 1'b0;
      lsu_status_q  <= ST_OK;
      lsu_started_q <= 1'b0;
    end else if (wb_valid) begin
      // Instruction leaves, start clean for the next one
      lsu_valid_q   <= 1'b0;
      lsu_status_q  <= ST_OK;
      lsu_started_q <= 1'b0;
    end else begin
      if (lsu_valid_i) begin
        lsu_valid_q  <= 1'b1;
        lsu_status_q <= lsu_status_i;
      end
      if (lsu_start_o) begin
        lsu_started_q <= 1'b1;
      end
    end
  end

  // Load data held across a halt
  always_ff @(posedge clk) begin
    if (!wb_valid && lsu_valid_i) begin
      lsu_rdata_q <= lsu_rdata_i;
    end
  end

endmodule

/* source/pipe_top.sv */
////////////////////////////////////////
// Pipeline back end: decode, execute,
// write back, load unit, register file
////////////////////////////////////////

`timescale 1ns/100ps

module pipe_top import wbx_pkg::*; #(
  parameter int DATA_LIMIT = 4096
) (
  input  logic            clk,
  input  logic            rst_n,
  // Instruction entry
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  output logic            ready_o,
  // Debug
  input  logic            halt_i,
  input  logic            watch_en_i,
  input  logic [XLEN-1:0] watch_addr_i,
  // Data bus
  output logic            data_req_o,
  output logic [XLEN-1:0] data_addr_o,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,
  // Retirement
  output logic            retire_valid_o,
  output logic            retire_we_o,
  output reg_addr_t       retire_rd_o,
  output logic [XLEN-1:0] retire_wdata_o,
  output status_e         retire_status_o
);

  logic            stall;
  // Register file reads
  reg_addr_t       rs1_addr, rs2_addr;
  logic [XLEN-1:0] rs1_data, rs2_data;
  // ID/EX
  logic            id_valid, id_illegal;
  op_e             id_op;
  reg_addr_t       id_rd, id_rs1, id_rs2;
  logic [XLEN-1:0] id_a, id_b, id_imm;
  // EX/WB
  logic            ex_valid, ex_we, ex_lsu_en;
  reg_addr_t       ex_rd;
  logic [XLEN-1:0] ex_result;
  status_e         ex_status;
  // Load unit handshake
  logic            lsu_start, lsu_valid;
  logic [XLEN-1:0] lsu_rdata;
  status_e         lsu_status;
  // Write-back port, also the forwarding source
  logic            rf_we;
  reg_addr_t       rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  // Host may strobe only while nothing is held
  assign ready_o        = !stall;
  assign retire_we_o    = rf_we;
  assign retire_rd_o    = rf_waddr;
  assign retire_wdata_o = rf_wdata;

  instr_decoder u_dec (
    .clk, .rst_n, .instr_valid_i, .instr_i, .stall_i(stall),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .id_valid_o(id_valid), .id_op_o(id_op), .id_rd_o(id_rd), .id_rs1_o(id_rs1),
    .id_rs2_o(id_rs2), .id_a_o(id_a), .id_b_o(id_b), .id_imm_o(id_imm),
    .id_illegal_o(id_illegal)
  );

  reg_file u_rf (
    .clk, .rst_n, .raddr_a_i(rs1_addr), .raddr_b_i(rs2_addr),
    .rdata_a_o(rs1_data), .rdata_b_o(rs2_data),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  alu_execute u_ex (
    .clk, .rst_n, .stall_i(stall),
    .id_valid_i(id_valid), .id_op_i(id_op), .id_rd_i(id_rd), .id_rs1_i(id_rs1),
    .id_rs2_i(id_rs2), .id_a_i(id_a), .id_b_i(id_b), .id_imm_i(id_imm),
    .id_illegal_i(id_illegal),
    .fwd_we_i(rf_we), .fwd_addr_i(rf_waddr), .fwd_data_i(rf_wdata),
    .ex_valid_o(ex_valid), .ex_rd_o(ex_rd), .ex_we_o(ex_we), .ex_lsu_en_o(ex_lsu_en),
    .ex_result_o(ex_result), .ex_status_o(ex_status)
  );

  // Load address is the execute result
  load_unit #(.DATA_LIMIT(DATA_LIMIT)) u_lsu (
    .clk, .rst_n, .start_i(lsu_start), .addr_i(ex_result),
    .watch_en_i, .watch_addr_i,
    .data_req_o, .data_addr_o, .data_rvalid_i, .data_rdata_i,
    .lsu_valid_o(lsu_valid), .lsu_rdata_o(lsu_rdata), .lsu_status_o(lsu_status)
  );

  wb_stage u_wb (
    .clk, .rst_n,
    .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_we_i(ex_we), .ex_lsu_en_i(ex_lsu_en),
    .ex_result_i(ex_result), .ex_status_i(ex_status), .halt_i,
    .lsu_valid_i(lsu_valid), .lsu_rdata_i(lsu_rdata), .lsu_status_i(lsu_status),
    .lsu_start_o(lsu_start), .wb_stall_o(stall),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .retire_valid_o, .retire_status_o
  );

endmodule

/* testbench/tb_pipe_top.sv */
////////////////////////////////////////
// Testbench for the pipeline back end
// Bus memory model, reference register
// model and directed tests
////////////////////////////////////////

`timescale 1ns/100ps

module tb_pipe_top import wbx_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int DRV          = 1;
  localparam int DATA_LIMIT   = 4096;
  localparam int N_TEST_INSTR = 25;
  localparam int HALT_CYCLES  = 10;

  logic            clk;
  logic            rst_n;
  logic            instr_valid;
  logic [XLEN-1:0] instr;
  logic            ready;
  logic            halt;
  logic            watch_en;
  logic [XLEN-1:0] watch_addr;
  logic            data_req;
  logic [XLEN-1:0] data_addr;
  logic            data_rvalid;
  logic [XLEN-1:0] data_rdata;
  logic            retire_valid;
  logic            retire_we;
  reg_addr_t       retire_rd;
  logic [XLEN-1:0] retire_wdata;
  status_e         retire_status;

  // Reference state and bookkeeping
  logic [XLEN-1:0] ref_regs [NREGS];
  int              cycle_cnt;
  int              req_count;
  int              err_count;
  int              n_checks;
  integer          seed;

  // Outstanding instructions in program order
  string           exp_name_q [$];
  int              exp_cycle_q [$];
  logic            exp_we_q [$];
  reg_addr_t       exp_rd_q [$];
  logic [XLEN-1:0] exp_data_q [$];
  status_e         exp_status_q [$];

  // Clean loads still waiting for their bus request
  string           exp_addr_name_q [$];
  logic [XLEN-1:0] exp_addr_q [$];

  pipe_top #(.DATA_LIMIT(DATA_LIMIT)) dut0 (
    .clk(clk), .rst_n(rst_n),
    .instr_valid_i(instr_valid), .instr_i(instr), .ready_o(ready),
    .halt_i(halt), .watch_en_i(watch_en), .watch_addr_i(watch_addr),
    .data_req_o(data_req), .data_addr_o(data_addr),
    .data_rvalid_i(data_rvalid), .data_rdata_i(data_rdata),
    .retire_valid_o(retire_valid), .retire_we_o(retire_we), .retire_rd_o(retire_rd),
    .retire_wdata_o(retire_wdata), .retire_status_o(retire_status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    n_checks++;
    if (act !== exp) begin
      err_count++;
      $display("** Error: %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input status_e exp, input status_e act);
    n_checks++;
    if (act !== exp) begin
      err_count++;
      $display("** Error: %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      err_count++;
      $display("** Error: %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    n_checks++;
    if (act !== exp) begin
      err_count++;
      $display("** Error: %s: expected r%0d, actual r%0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      err_count++;
      $display("** Error: %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Word pattern over the whole word index
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    idx = addr >> 2;
    return (idx * 32'h9E37_79B9) ^ (idx << 7) ^ 32'h1357_0000;
  endfunction

  function automatic logic [XLEN-1:0] encode(input logic [3:0] opc, input reg_addr_t rd,
      input reg_addr_t rs1, input reg_addr_t rs2, input logic [15:0] imm);
    return {opc, rd, rs1, rs2, imm};
  endfunction

  // Expected write, data, status and load address from the architectural rules
  task automatic predict_result(input logic [XLEN-1:0] word, output logic we,
      output logic [XLEN-1:0] data, output status_e status,
      output logic [XLEN-1:0] addr);
    logic [3:0]      opc;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    opc  = word[OPC_MSB:OPC_LSB];
    a    = ref_regs[word[RS1_MSB:RS1_LSB]];
    b    = ref_regs[word[RS2_MSB:RS2_LSB]];
    addr = a + {{16{word[IMM_MSB]}}, word[IMM_MSB:IMM_LSB]};
    we     = 1'b1;
    status = ST_OK;
    data   = '0;
    case (opc)
      OP_ADD:  data = a + b;
      OP_SUB:  data = a - b;
      OP_AND:  data = a & b;
      OP_XOR:  data = a ^ b;
      OP_ADDI: data = addr;
      OP_LOAD: begin
        // Alignment first, then range, then watch
        if (addr[1:0] != 2'b00) status = ST_MISALIGN;
        else if (addr >= DATA_LIMIT) status = ST_PROTECT;
        else if (watch_en && (addr == watch_addr)) status = ST_WATCH;
        else data = mem_word(addr);
        we = (status == ST_OK);
      end
      default: begin
        we     = 1'b0;
        status = ST_ILLEGAL;
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Bus memory and retirement monitor
  ////////////////////////////////////////

  // Answers each request after 0 to 3 cycles
  always begin : bus_memory
    int              lat;
    logic [XLEN-1:0] req_addr;
    @(posedge clk);
    #(DRV);
    if (rst_n && data_req) begin
      lat      = $unsigned($random(seed)) % 4;
      req_addr = data_addr;
      if (exp_addr_q.size() == 0) begin
        err_count++;
        $display("Bus request to address %h with no clean load outstanding", req_addr);
      end else begin
        check_data({exp_addr_name_q.pop_front(), " address"}, exp_addr_q.pop_front(),
                   req_addr);
      end
      repeat (lat) next_cycle();
      data_rvalid = 1'b1;
      data_rdata  = mem_word(req_addr);
      next_cycle();
      data_rvalid = 1'b0;
    end
  end

  always @(posedge clk) begin : retire_monitor
    string name;
    int    exp_cycle;
    logic  exp_we;
    if (rst_n && data_req) req_count++;
    if (rst_n && retire_valid) begin
      if (exp_name_q.size() == 0) begin
        err_count++;
        $display("Retirement in cycle %0d with no instruction outstanding", cycle_cnt);
      end else begin
        name      = exp_name_q.pop_front();
        exp_cycle = exp_cycle_q.pop_front();
        exp_we    = exp_we_q.pop_front();
        // Timing is checked only where no stall can occur
        if (exp_cycle >= 0) check_count({name, " retire cycle"}, exp_cycle, cycle_cnt);
        check_status({name, " status"}, exp_status_q.pop_front(), retire_status);
        check_flag({name, " write enable"}, exp_we, retire_we);
        if (exp_we) begin
          check_reg({name, " rd"}, exp_rd_q.pop_front(), retire_rd);
          check_data({name, " wdata"}, exp_data_q.pop_front(), retire_wdata);
        end else begin
          void'(exp_rd_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end
    end
    cycle_cnt++;
  end

  ////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #(DRV);
  endtask

  // Strobe one instruction and queue its expected retirement
  task automatic run_instr(input string name, input logic [XLEN-1:0] word, input bit timed);
    logic            we;
    logic [XLEN-1:0] data;
    status_e         status;
    logic [XLEN-1:0] addr;
    reg_addr_t       rd;
    while (!ready) next_cycle();
    predict_result(word, we, data, status, addr);
    rd = word[RD_MSB:RD_LSB];
    exp_name_q.push_back(name);
    exp_cycle_q.push_back(timed ? cycle_cnt + 2 : -1);
    exp_we_q.push_back(we);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_status_q.push_back(status);
    // A clean load must reach the bus with this address
    if ((word[OPC_MSB:OPC_LSB] == OP_LOAD) && (status == ST_OK)) begin
      exp_addr_name_q.push_back(name);
      exp_addr_q.push_back(addr);
    end
    if (we && (rd != '0)) ref_regs[rd] = data;
    instr_valid = 1'b1;
    instr       = word;
    next_cycle();
    instr_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_name_q.size() != 0) next_cycle();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  // Distance one uses forwarding, distance two the write-through
  task automatic alu_chain();
    run_instr("alu_chain addi r1", encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0005), 1'b1);
    run_instr("alu_chain addi r2", encode(OP_ADDI, 4'd2, 4'd1, 4'd0, 16'hFFF0), 1'b1);
    run_instr("alu_chain add r3", encode(OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0000), 1'b1);
    run_instr("alu_chain sub r4", encode(OP_SUB, 4'd4, 4'd3, 4'd1, 16'h0000), 1'b1);
    run_instr("alu_chain xor r5", encode(OP_XOR, 4'd5, 4'd4, 4'd2, 16'h0000), 1'b1);
    run_instr("alu_chain and r6", encode(OP_AND, 4'd6, 4'd5, 4'd3, 16'h0000), 1'b1);
    drain();
  endtask

  task automatic load_latency();
    int          req_before;
    logic [15:0] offset;
    req_before = req_count;
    for (int i = 0; i < 4; i++) begin
      offset = 16'(i * 'h124 + 'h10);
      run_instr("load_latency load",
                encode(OP_LOAD, reg_addr_t'(2 + i), 4'd0, 4'd0, offset), 1'b0);
      // Consumer right behind the load
      run_instr("load_latency add",
                encode(OP_ADD, reg_addr_t'(6 + i), reg_addr_t'(2 + i), 4'd1, 16'h0), 1'b0);
    end
    drain();
    check_count("load_latency requests", req_before + 4, req_count);
  endtask

  task automatic load_faults();
    int req_before;
    watch_addr = 32'h0000_0040;
    watch_en   = 1'b1;
    run_instr("load_faults addi r8", encode(OP_ADDI, 4'd8, 4'd0, 4'd0, 16'h0077), 1'b1);
    req_before = req_count;
    run_instr("load_faults misalign", encode(OP_LOAD, 4'd8, 4'd0, 4'd0, 16'h0006), 1'b0);
    run_instr("load_faults limit", encode(OP_LOAD, 4'd8, 4'd0, 4'd0, 16'h1000), 1'b0);
    run_instr("load_faults negative", encode(OP_LOAD, 4'd8, 4'd0, 4'd0, 16'hFFFC), 1'b0);
    // Misaligned and out of range at once
    run_instr("load_faults priority", encode(OP_LOAD, 4'd8, 4'd0, 4'd0, 16'h1002), 1'b0);
    run_instr("load_faults watch", encode(OP_LOAD, 4'd8, 4'd0, 4'd0, 16'h0040), 1'b0);
    run_instr("load_faults add r9", encode(OP_ADD, 4'd9, 4'd8, 4'd0, 16'h0000), 1'b0);
    drain();
    check_count("load_faults requests", req_before, req_count);
    watch_en = 1'b0;
  endtask

  // Load completes under halt, retires once after release
  task automatic halt_across_load();
    int req_before;
    req_before = req_count;
    run_instr("halt_load load", encode(OP_LOAD, 4'd13, 4'd0, 4'd0, 16'h0200), 1'b0);
    halt = 1'b1;
    repeat (HALT_CYCLES) begin
      next_cycle();
      check_flag("halt_load retire held", 1'b0, retire_valid);
    end
    check_count("halt_load requests", req_before + 1, req_count);
    halt = 1'b0;
    run_instr("halt_load add r14", encode(OP_ADD, 4'd14, 4'd13, 4'd0, 16'h0000), 1'b0);
    drain();
  endtask

  task automatic illegal_opcode();
    run_instr("illegal_opcode", encode(4'hA, 4'd6, 4'd1, 4'd2, 16'h1234), 1'b1);
    run_instr("illegal_opcode add r12", encode(OP_ADD, 4'd12, 4'd6, 4'd0, 16'h0000), 1'b1);
    drain();
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin : main
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    halt        = 1'b0;
    watch_en    = 1'b0;
    watch_addr  = '0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    seed        = 34;
    cycle_cnt   = 0;
    req_count   = 0;
    err_count   = 0;
    n_checks    = 0;
    for (int i = 0; i < NREGS; i++) ref_regs[i] = '0;
    repeat (4) @(posedge clk);
    #(DRV);
    rst_n = 1'b1;
    next_cycle();
    check_flag("reset ready", 1'b1, ready);
    check_flag("reset retire_valid", 1'b0, retire_valid);
    check_flag("reset retire_we", 1'b0, retire_we);
    check_flag("reset data_req", 1'b0, data_req);
    alu_chain();
    load_latency();
    load_faults();
    halt_across_load();
    illegal_opcode();
    $display("Checks run: %0d, errors: %0d", n_checks, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Twenty cycles per test instruction
  initial begin : watchdog
    #(N_TEST_INSTR * 20 * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", N_TEST_INSTR * 20);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sim.f */
source/wbx_pkg.sv
source/reg_file.sv
source/instr_decoder.sv
source/alu_execute.sv
source/load_unit.sv
source/wb_stage.sv
source/pipe_top.sv
testbench/tb_pipe_top.sv
